// File: hdl/enc_pkg.sv
// --------------------------------------------------------------------------
// shared constants for the quadrature encoder interface
// address map fields, counter widths and reset values used by the rtl
// and the testbench alike; modules pull them in by wildcard import
// --------------------------------------------------------------------------

`default_nettype none

package enc_pkg;

   // -----------------------------------------------------------------------
   // counter widths and reset values
   // -----------------------------------------------------------------------
   localparam int          pos_width    = 24;          // position count width
   localparam logic [23:0] enc_midrange = 24'h800000;  // preload/position reset

   // both period counters stop here instead of wrapping
   localparam logic [30:0] perd_max = 31'h7fff_ffff;

   // -----------------------------------------------------------------------
   // address map
   // reg address layout: [15:12] space, [7:4] channel, [3:0] offset
   // -----------------------------------------------------------------------
   localparam logic [3:0] addr_main = 4'h0;  // encoder register space

   localparam logic [3:0] off_enc_load = 4'h4;  // preload, r/w
   localparam logic [3:0] off_enc_data = 4'h5;  // position + overflow, ro
   localparam logic [3:0] off_enc_perd = 4'h6;  // last quarter period + dir, ro
   localparam logic [3:0] off_enc_run  = 4'h7;  // running period, ro

endpackage

`default_nettype wire

// File: hdl/enc_debounce.sv
// --------------------------------------------------------------------------
// debounce filter for one raw encoder line
// two-flop synchronizer followed by a stability counter; the output only
// follows the input once it has been steady for 2**debounce_bits cycles
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_debounce #(
   parameter int debounce_bits = 3  // stability window is 2**debounce_bits
) (
   input  logic sysclk,
   input  logic rst_n,
   input  logic raw,    // asynchronous line straight from the connector
   output logic filt    // clean, synchronous level
);

   logic [1:0]               sync;  // sync[1] is the safe sample
   logic [debounce_bits-1:0] cnt;   // cycles the input has differed from filt

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         sync <= 2'b00;
         cnt  <= '0;
         filt <= 1'b0;
      end else begin
         sync <= {sync[0], raw};
         if (sync[1] == filt) begin
            cnt <= '0;              // input agrees, restart the window
         end else begin
            cnt <= cnt + 1'b1;
            // last count of the window, counter wraps to zero here
            if (&cnt)
               filt <= sync[1];
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/enc_quad.sv
// --------------------------------------------------------------------------
// quadrature decoder and position counter for one encoder channel
// counts every quarter step up or down, keeps a sticky overflow bit and
// loads the preload value on a one-cycle set pulse
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_quad (
   input  logic                         sysclk,
   input  logic                         rst_n,
   input  logic                         a,          // filtered a line
   input  logic                         b,          // filtered b line
   input  logic                         set,        // load preload, one cycle
   input  logic [enc_pkg::pos_width-1:0] preload,
   output logic [enc_pkg::pos_width:0]   quad_data,  // {overflow, position}
   output logic                         dir         // last step, 1 = up
);

   import enc_pkg::*;

   logic                 a_prev;  // a/b as seen last cycle
   logic                 b_prev;
   logic                 step;    // either line moved
   logic                 up;      // direction of this step
   logic [pos_width-1:0] count;
   logic                 ovf;     // sticky, cleared only by preload

   // any change on a or b is one quarter step
   assign step = (a ^ a_prev) | (b ^ b_prev);

   // a leading b counts up: 00 -> 10 -> 11 -> 01 -> 00
   // the new a differs from the old b exactly on forward steps
   assign up = a ^ b_prev;

   // -----------------------------------------------------------------------
   // state and counter
   // -----------------------------------------------------------------------
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         a_prev <= 1'b0;         // filters come out of reset low
         b_prev <= 1'b0;
         count  <= enc_midrange;
         ovf    <= 1'b0;
         dir    <= 1'b0;
      end else begin
         a_prev <= a;
         b_prev <= b;
         if (set) begin
            count <= preload;    // preload beats a step in the same cycle
            ovf   <= 1'b0;
         end else if (step) begin
            dir <= up;
            if (up) begin
               count <= count + 1'b1;
               if (&count)
                  ovf <= 1'b1;    // wrapped past all ones
            end else begin
               count <= count - 1'b1;
               if (count == '0)
                  ovf <= 1'b1;    // wrapped below zero
            end
         end
      end
   end

   assign quad_data = {ovf, count};

endmodule

`default_nettype wire

// File: hdl/enc_period.sv
// --------------------------------------------------------------------------
// quarter-step interval timer for velocity estimation
// a free counter measures the cycles between filtered a/b edges; each edge
// latches the count as the last period and restarts the counter at 1
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_period (
   input  logic        sysclk,
   input  logic        rst_n,
   input  logic        a,          // filtered a line
   input  logic        b,          // filtered b line
   input  logic        dir,        // direction of the last step, from enc_quad
   output logic [31:0] perd_data,  // {dir, last quarter period}
   output logic [31:0] run_data    // {0, cycles since the last edge}
);

   import enc_pkg::*;

   logic        a_prev;    // previous filtered levels
   logic        b_prev;
   logic        edge_det;  // quarter step seen this cycle
   logic [30:0] run_cnt;   // running period
   logic [30:0] perd_cnt;  // period latched at the last edge

   assign edge_det = (a ^ a_prev) | (b ^ b_prev);

   // -----------------------------------------------------------------------
   // running counter and period capture
   // -----------------------------------------------------------------------
   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         a_prev   <= 1'b0;
         b_prev   <= 1'b0;
         run_cnt  <= '0;
         perd_cnt <= '0;
      end else begin
         a_prev <= a;
         b_prev <= b;
         if (edge_det) begin
            // count reached here equals the cycles between two edges
            perd_cnt <= run_cnt;
            run_cnt  <= 31'd1;       // this cycle is the first of the new interval
         end else if (run_cnt != perd_max) begin
            run_cnt <= run_cnt + 1'b1;
         end
         // else stalled at perd_max, encoder stopped
      end
   end

   // -----------------------------------------------------------------------
   // output words
   // -----------------------------------------------------------------------

   // enc_quad updates dir on the same edge as perd_cnt,
   // so the two always describe the same step
   assign perd_data = {dir, perd_cnt};

   assign run_data = {1'b0, run_cnt};  // msb unused

endmodule

`default_nettype wire

// File: hdl/enc_ctrl.sv
// --------------------------------------------------------------------------
// per-channel encoder datapath and register access
// builds the filters, position counters and period timers for every
// channel, holds the preload registers and muxes one channel for reading
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_ctrl #(
   parameter int num_channels  = 4,  // channels 0 .. num_channels-1
   parameter int debounce_bits = 3   // filter window, see enc_debounce
) (
   input  logic                    sysclk,
   input  logic                    rst_n,
   input  logic [num_channels-1:0] enc_a,           // raw encoder a lines
   input  logic [num_channels-1:0] enc_b,           // raw encoder b lines
   input  logic [3:0]              reg_raddr_chan,  // channel being read
   input  logic [15:0]             reg_waddr,
   input  logic [31:0]             reg_wdata,
   input  logic                    reg_wen,         // single-cycle write strobe
   output logic [31:0]             reg_preload,
   output logic [31:0]             reg_quad_data,
   output logic [31:0]             reg_perd_data,
   output logic [31:0]             reg_run_data
);

   import enc_pkg::*;

   logic [num_channels-1:0] a_filt;   // debounced lines
   logic [num_channels-1:0] b_filt;
   logic [num_channels-1:0] dir;      // last step direction per channel
   logic [num_channels-1:0] set_enc;  // preload pulse per channel

   logic [pos_width-1:0] preload   [num_channels];
   logic [pos_width:0]   quad_data [num_channels];  // overflow in msb
   logic [31:0]          perd_data [num_channels];
   logic [31:0]          run_data  [num_channels];

   logic       load_hit;  // write addresses some preload register
   logic [3:0] wr_chan;

   // -----------------------------------------------------------------------
   // preload write decode
   // -----------------------------------------------------------------------
   assign wr_chan  = reg_waddr[7:4];
   assign load_hit = reg_wen && (reg_waddr[15:12] == addr_main) &&
                     (reg_waddr[3:0] == off_enc_load);

   // -----------------------------------------------------------------------
   // per-channel datapath
   // -----------------------------------------------------------------------
   for (genvar i = 0; i < num_channels; i++) begin : chan_loop
      enc_debounce #(.debounce_bits(debounce_bits)) filt_a (
         .sysclk(sysclk), .rst_n(rst_n), .raw(enc_a[i]), .filt(a_filt[i])
      );
      enc_debounce #(.debounce_bits(debounce_bits)) filt_b (
         .sysclk(sysclk), .rst_n(rst_n), .raw(enc_b[i]), .filt(b_filt[i])
      );

      enc_quad quad (
         .sysclk(sysclk), .rst_n(rst_n), .a(a_filt[i]), .b(b_filt[i]),
         .set(set_enc[i]), .preload(preload[i]),
         .quad_data(quad_data[i]), .dir(dir[i])
      );

      enc_period perd (
         .sysclk(sysclk), .rst_n(rst_n), .a(a_filt[i]), .b(b_filt[i]),
         .dir(dir[i]), .perd_data(perd_data[i]), .run_data(run_data[i])
      );

      // channel numbers past num_channels match no slice, write is dropped
      always_ff @(posedge sysclk) begin
         if (!rst_n) begin
            preload[i] <= enc_midrange;
            set_enc[i] <= 1'b0;
         end else begin
            set_enc[i] <= load_hit && (int'(wr_chan) == i);  // one cycle only
            if (load_hit && (int'(wr_chan) == i))
               preload[i] <= reg_wdata[pos_width-1:0];
         end
      end
   end

   // -----------------------------------------------------------------------
   // read select, all zero for a channel that does not exist
   // -----------------------------------------------------------------------
   always_comb begin
      reg_preload   = '0;
      reg_quad_data = '0;
      reg_perd_data = '0;
      reg_run_data  = '0;
      for (int i = 0; i < num_channels; i++) begin
         if (int'(reg_raddr_chan) == i) begin
            reg_preload   = {{(32-pos_width){1'b0}}, preload[i]};
            reg_quad_data = {{(31-pos_width){1'b0}}, quad_data[i]};
            reg_perd_data = perd_data[i];
            reg_run_data  = run_data[i];
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/enc_read_port.sv
// --------------------------------------------------------------------------
// register read port of the encoder block
// decodes space and offset of a read, registers the selected word and
// returns it with a valid strobe one cycle after the read strobe
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_read_port (
   input  logic        sysclk,
   input  logic        rst_n,
   input  logic        reg_ren,          // single-cycle read strobe
   input  logic [3:0]  reg_raddr_space,  // address bits 15..12
   input  logic [3:0]  reg_raddr_off,    // address bits 3..0
   input  logic [31:0] reg_preload,      // words of the addressed channel
   input  logic [31:0] reg_quad_data,
   input  logic [31:0] reg_perd_data,
   input  logic [31:0] reg_run_data,
   output logic [31:0] reg_rdata,
   output logic        reg_rvalid
);

   import enc_pkg::*;

   logic [31:0] rd_word;  // word selected by the current address

   always_comb begin
      rd_word = '0;  // foreign space or unknown offset reads zero
      if (reg_raddr_space == addr_main) begin
         case (reg_raddr_off)
            off_enc_load: rd_word = reg_preload;
            off_enc_data: rd_word = reg_quad_data;
            off_enc_perd: rd_word = reg_perd_data;
            off_enc_run:  rd_word = reg_run_data;
            default:      rd_word = '0;
         endcase
      end
   end

   always_ff @(posedge sysclk) begin
      if (!rst_n) begin
         reg_rdata  <= '0;
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_ren;      // valid exactly one cycle after strobe
         if (reg_ren)
            reg_rdata <= rd_word;    // held until the next read
      end
   end

endmodule

`default_nettype wire

// File: hdl/enc_top.sv
// --------------------------------------------------------------------------
// top level of the multi-channel quadrature encoder interface
// connects the encoder datapath to the register port; set num_channels
// and debounce_bits here, they are passed down to every channel
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_top #(
   parameter int num_channels  = 4,
   parameter int debounce_bits = 3
) (
   input  logic                    sysclk,
   input  logic                    rst_n,
   input  logic [num_channels-1:0] enc_a,
   input  logic [num_channels-1:0] enc_b,
   input  logic                    reg_wen,    // write strobe, one cycle
   input  logic [15:0]             reg_waddr,
   input  logic [31:0]             reg_wdata,
   input  logic                    reg_ren,    // read strobe, one cycle
   input  logic [15:0]             reg_raddr,
   output logic [31:0]             reg_rdata,
   output logic                    reg_rvalid  // rdata valid, one cycle
);

   logic [31:0] preload_w;  // channel words on their way to the read port
   logic [31:0] quad_w;
   logic [31:0] perd_w;
   logic [31:0] run_w;

   enc_ctrl #(
      .num_channels(num_channels),
      .debounce_bits(debounce_bits)
   ) ctrl (
      .sysclk(sysclk), .rst_n(rst_n), .enc_a(enc_a), .enc_b(enc_b),
      .reg_raddr_chan(reg_raddr[7:4]),  // channel field
      .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
      .reg_preload(preload_w), .reg_quad_data(quad_w),
      .reg_perd_data(perd_w), .reg_run_data(run_w)
   );

   enc_read_port rd_port (
      .sysclk(sysclk), .rst_n(rst_n), .reg_ren(reg_ren),
      .reg_raddr_space(reg_raddr[15:12]), .reg_raddr_off(reg_raddr[3:0]),
      .reg_preload(preload_w), .reg_quad_data(quad_w),
      .reg_perd_data(perd_w), .reg_run_data(run_w),
      .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid)
   );

endmodule

`default_nettype wire

// File: verification/enc_checker.sv
// --------------------------------------------------------------------------
// concurrent assertions for the encoder interface, bound into enc_top
// read handshake timing and single-step position changes per channel
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_checker #(
   parameter int num_channels = 4
) (
   input logic                        sysclk,
   input logic                        rst_n,
   input logic                        reg_ren,
   input logic                        reg_rvalid,
   input logic [num_channels-1:0]     set_enc,                  // preload pulses
   input logic [enc_pkg::pos_width:0] quad_data [num_channels]  // {ovf, position}
);

   import enc_pkg::*;

   int fail_cnt;  // failed assertions, read at the end of the run

   initial fail_cnt = 0;

   // position moved by -1, 0 or +1 modulo the counter width
   function automatic bit single_step(input logic [pos_width-1:0] cur,
                                      input logic [pos_width-1:0] prev);
      logic [pos_width-1:0] d;
      d = cur - prev;
      return (d == '0) || (d == 1) || (d == '1);
   endfunction

   // -----------------------------------------------------------------------
   // read handshake
   // -----------------------------------------------------------------------
   rvalid_after_ren: assert property (@(posedge sysclk) disable iff (!rst_n)
      reg_ren |=> reg_rvalid)
      else begin
         $error("reg_rvalid missing one cycle after reg_ren");
         fail_cnt++;
      end

   rvalid_only_after_ren: assert property (@(posedge sysclk) disable iff (!rst_n)
      reg_rvalid |-> $past(reg_ren))
      else begin
         $error("reg_rvalid without a read strobe");
         fail_cnt++;
      end

   rvalid_low_after_reset: assert property (@(posedge sysclk)
      $rose(rst_n) |-> !reg_rvalid)
      else begin
         $error("reg_rvalid high right after reset");
         fail_cnt++;
      end

   // -----------------------------------------------------------------------
   // position counters, a preload may jump anywhere
   // -----------------------------------------------------------------------
   for (genvar i = 0; i < num_channels; i++) begin : pos_chk
      pos_single_step: assert property (@(posedge sysclk) disable iff (!rst_n)
         !$past(set_enc[i]) |->
            single_step(quad_data[i][pos_width-1:0], $past(quad_data[i][pos_width-1:0])))
         else begin
            $error("position of channel %0d moved by more than one", i);
            fail_cnt++;
         end
   end

endmodule

bind enc_top enc_checker #(.num_channels(num_channels)) chk (
   .sysclk(sysclk), .rst_n(rst_n), .reg_ren(reg_ren), .reg_rvalid(reg_rvalid),
   .set_enc(ctrl.set_enc), .quad_data(ctrl.quad_data)
);

`default_nettype wire

// File: verification/enc_tb.sv
// --------------------------------------------------------------------------
// directed testbench for the quadrature encoder interface
// drives quarter steps and glitches on the raw lines, accesses registers
// through the strobe port and compares against a per-channel model
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module enc_tb;

   import enc_pkg::*;

   localparam int n_chan       = 4;
   localparam int hold_cycles  = 40;  // level hold per quarter step beyond the filter
   localparam int glitch_ticks = 3 + hold_cycles;  // pulse plus settle time of one glitch
   localparam int max_steps    = 64;  // bound on steps and glitches of all tests
   localparam int watchdog_ns  = max_steps * hold_cycles * 10 + 2000;

   logic              sysclk;
   logic              rst_n;
   logic [n_chan-1:0] enc_a;
   logic [n_chan-1:0] enc_b;
   logic              reg_wen;
   logic [15:0]       reg_waddr;
   logic [31:0]       reg_wdata;
   logic              reg_ren;
   logic [15:0]       reg_raddr;
   logic [31:0]       reg_rdata;
   logic              reg_rvalid;

   logic [23:0] pos_model [n_chan];  // expected position per channel
   logic        ovf_model [n_chan];  // expected sticky overflow
   logic [31:0] rnd;                 // xorshift state

   enc_top #(.num_channels(n_chan), .debounce_bits(3)) UUT (
      .sysclk(sysclk), .rst_n(rst_n), .enc_a(enc_a), .enc_b(enc_b),
      .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
      .reg_ren(reg_ren), .reg_raddr(reg_raddr),
      .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid)
   );

   always #5 sysclk = ~sysclk;  // 100 MHz

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // space, channel, offset
   function automatic logic [15:0] enc_addr(input logic [3:0] space, input int ch,
                                            input logic [3:0] off);
      return {space, 4'h0, 4'(ch), off};
   endfunction

   task automatic tick();  // inputs change 1 ns after the edge
      @(posedge sysclk);
      #1;
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("error at %0d ns: %s, read %h, expected %h", $time, what, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "value mismatch");
      end
   endtask

   // -----------------------------------------------------------------------
   // register access
   // -----------------------------------------------------------------------
   task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
      reg_waddr = addr;
      reg_wdata = data;
      reg_wen   = 1'b1;
      tick();
      reg_wen = 1'b0;
      tick();  // counter loads one edge after the preload register
   endtask

   task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
      int waited;
      waited    = 0;
      reg_raddr = addr;
      reg_ren   = 1'b1;
      tick();
      reg_ren = 1'b0;
      while (!reg_rvalid && waited < 8) begin
         tick();
         waited++;
      end
      if (!reg_rvalid) begin
         $display("read of address %h never got reg_rvalid", addr);
         $display("ERRORS FOUND");
         $fatal(1, "read timeout");
      end
      data = reg_rdata;
   endtask

   task automatic check_pos(input int ch);
      logic [31:0] rd;
      read_reg(enc_addr(addr_main, ch, off_enc_data), rd);
      check(rd, {7'b0, ovf_model[ch], pos_model[ch]}, $sformatf("position ch %0d", ch));
   endtask

   // -----------------------------------------------------------------------
   // encoder stimulus
   // -----------------------------------------------------------------------
   task automatic step_enc(input int ch, input bit fwd, input int hold);
      if ((enc_a[ch] == enc_b[ch]) == fwd)  // forward steps let a lead b
         enc_a[ch] = ~enc_a[ch];
      else
         enc_b[ch] = ~enc_b[ch];
      if (fwd) begin
         if (pos_model[ch] == 24'hff_ffff)
            ovf_model[ch] = 1'b1;
         pos_model[ch] = pos_model[ch] + 24'd1;
      end else begin
         if (pos_model[ch] == 24'h0)
            ovf_model[ch] = 1'b1;
         pos_model[ch] = pos_model[ch] - 24'd1;
      end
      repeat (hold) tick();
   endtask

   task automatic glitch(input int ch, input bit on_a);
      if (on_a)
         enc_a[ch] = ~enc_a[ch];
      else
         enc_b[ch] = ~enc_b[ch];
      repeat (3) tick();  // shorter than the 8 cycle window
      if (on_a)
         enc_a[ch] = ~enc_a[ch];
      else
         enc_b[ch] = ~enc_b[ch];
      repeat (hold_cycles) tick();
   endtask

   // -----------------------------------------------------------------------
   // tests
   // -----------------------------------------------------------------------
   task automatic test_reset_values();
      logic [31:0] rd;
      for (int ch = 0; ch < n_chan; ch++) begin
         read_reg(enc_addr(addr_main, ch, off_enc_load), rd);
         check(rd, {8'b0, enc_midrange}, "preload after reset");
         check_pos(ch);
         read_reg(enc_addr(addr_main, ch, off_enc_perd), rd);
         check(rd, 32'h0, "last period after reset");
         read_reg(enc_addr(addr_main, ch, off_enc_run), rd);  // counts up from reset
         check({31'b0, rd[31] == 1'b0 && rd != 0}, 32'd1, "running period after reset");
      end
   endtask

   task automatic test_forward_random();
      int ch;
      int n;
      for (int r = 0; r < 4; r++) begin
         rnd = xorshift(rnd);
         ch  = int'(rnd[1:0]);       // 4 channels
         n   = int'(rnd[10:8]) + 1;  // 1 to 8 steps
         repeat (n) step_enc(ch, 1'b1, hold_cycles);
         for (int c = 0; c < n_chan; c++)
            check_pos(c);
      end
   endtask

   task automatic test_reverse_period();
      int          ch;
      int          n;
      logic [31:0] rd;
      rnd = xorshift(rnd);
      ch  = int'(rnd[1:0]);
      n   = int'(rnd[9:8]) + 2;  // at least two so the last interval is one hold
      repeat (3) step_enc(ch, 1'b1, hold_cycles);
      read_reg(enc_addr(addr_main, ch, off_enc_perd), rd);
      check(rd, {1'b1, 31'(hold_cycles)}, "period after forward steps");
      repeat (n) step_enc(ch, 1'b0, hold_cycles);
      read_reg(enc_addr(addr_main, ch, off_enc_perd), rd);
      check(rd, {1'b0, 31'(hold_cycles)}, "period after reverse steps");
      check_pos(ch);
   endtask

   task automatic test_preload();
      logic [31:0] rd;
      write_reg(enc_addr(addr_main, 1, off_enc_load), 32'hab12_3456);  // top byte dropped
      pos_model[1] = 24'h12_3456;
      ovf_model[1] = 1'b0;
      read_reg(enc_addr(addr_main, 1, off_enc_load), rd);
      check(rd, 32'h0012_3456, "preload read back");
      check_pos(1);
      write_reg(enc_addr(addr_main, 1, off_enc_data), 32'h0000_0055);  // read-only word
      write_reg(enc_addr(4'h3, 1, off_enc_load), 32'h0000_0077);       // other space
      read_reg(enc_addr(addr_main, 1, off_enc_load), rd);
      check(rd, 32'h0012_3456, "preload after stray writes");
      check_pos(1);
      write_reg(enc_addr(addr_main, 1, off_enc_load), 32'h00ff_ffff);
      pos_model[1] = 24'hff_ffff;
      step_enc(1, 1'b1, hold_cycles);  // wraps to zero and sets overflow
      check_pos(1);
      write_reg(enc_addr(addr_main, 1, off_enc_load), 32'h0000_0010);
      pos_model[1] = 24'h00_0010;
      ovf_model[1] = 1'b0;
      check_pos(1);
   endtask

   task automatic test_glitch();
      logic [31:0] rd;
      glitch(2, 1'b1);
      glitch(2, 1'b0);
      glitch(3, 1'b1);
      check_pos(2);
      check_pos(3);
      // a glitch that got through would restart the running period
      read_reg(enc_addr(addr_main, 2, off_enc_run), rd);
      check({31'b0, rd >= 32'(3 * glitch_ticks)}, 32'd1,
            "running period ch 2 after glitches");
      read_reg(enc_addr(addr_main, 3, off_enc_run), rd);
      check({31'b0, rd >= 32'(glitch_ticks)}, 32'd1,
            "running period ch 3 after glitches");
   endtask

   task automatic test_idle_reads();
      logic [31:0] first;
      logic [31:0] second;
      read_reg(enc_addr(addr_main, 0, off_enc_run), first);
      repeat (10) tick();
      read_reg(enc_addr(addr_main, 0, off_enc_run), second);
      check({31'b0, second > first}, 32'd1, "running period grows while idle");
      read_reg(enc_addr(addr_main, 0, 4'h9), first);
      check(first, 32'h0, "unknown offset");
      read_reg(enc_addr(addr_main, 6, off_enc_data), first);
      check(first, 32'h0, "channel out of range");
   endtask

   // -----------------------------------------------------------------------
   // main sequence and watchdog
   // -----------------------------------------------------------------------
   initial begin
      sysclk    = 1'b0;
      rst_n     = 1'b0;
      enc_a     = '0;
      enc_b     = '0;
      reg_wen   = 1'b0;
      reg_waddr = '0;
      reg_wdata = '0;
      reg_ren   = 1'b0;
      reg_raddr = '0;
      rnd       = 32'h0840_671f;
      for (int c = 0; c < n_chan; c++) begin
         pos_model[c] = enc_midrange;
         ovf_model[c] = 1'b0;
      end
      repeat (3) @(posedge sysclk);
      #1;
      rst_n = 1'b1;
      test_reset_values();
      test_forward_random();
      test_reverse_period();
      test_preload();
      test_glitch();
      test_idle_reads();
      repeat (2) tick();
      if (UUT.chk.fail_cnt != 0) begin
         $display("%0d assertion failures in the checker", UUT.chk.fail_cnt);
         $display("ERRORS FOUND");
         $fatal(1, "assertions failed");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

   initial begin
      #(watchdog_ns);
      $display("timeout, tests still running after %0d ns", watchdog_ns);
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: all.f
hdl/enc_pkg.sv
hdl/enc_debounce.sv
hdl/enc_quad.sv
hdl/enc_period.sv
hdl/enc_ctrl.sv
hdl/enc_read_port.sv
hdl/enc_top.sv
verification/enc_checker.sv
verification/enc_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = enc_tb
FLIST    = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = ERRORS FOUND
PASS_MSG = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; \
	elif grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
